/* project.f */
source/csr_pkg.sv
source/csr_timer.sv
source/csr_file.sv
source/csr_decode.sv
source/csr_trap.sv
source/csr_unit.sv
verif/csr_checker.sv
verif/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the csr unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module csr_unit_tb -o csr_sim
./obj_dir/csr_sim > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

/* verif/csr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

    logic        clk;
    logic        rstn;
    logic        req;
    logic        ack;
    logic [31:0] instr;
    logic [31:0] rj_value;
    logic [31:0] rd_value;
    logic [31:0] pc;
    logic [7:0]  hw_int;
    logic [31:0] rdata;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        has_int;

    int          seed = 76;
    int          tb_errors = 0;
    int          total;
    logic [31:0] last_rdata;
    logic [31:0] pc_now = 32'h1c00_0000;
    logic [13:0] regs [7];
    logic [31:0] exc_words [3];

    csr_unit dut (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .ack         (ack),
        .instr       (instr),
        .rj_value    (rj_value),
        .rd_value    (rd_value),
        .pc          (pc),
        .hw_int      (hw_int),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .has_int     (has_int)
    );

    csr_checker u_checker (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .ack         (ack),
        .instr       (instr),
        .rj_value    (rj_value),
        .rd_value    (rd_value),
        .pc          (pc),
        .hw_int      (hw_int),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] csr_word(input logic [13:0] num, input logic [4:0] rj);
        csr_instr_u iw;
        iw.csr.op = OPC_CSR;
        iw.csr.csr_num = num;
        iw.csr.rj = rj;
        iw.csr.rd = 5'd4;
        return iw;
    endfunction

    function automatic logic [31:0] code_word(input logic [16:0] opc, input logic [14:0] code);
        csr_instr_u iw;
        iw.code.op = opc;
        iw.code.code = code;
        return iw;
    endfunction

    // one full four-phase transfer
    task automatic run_cmd(input logic [31:0] word, input logic [31:0] rj,
                           input logic [31:0] rd);
        int t;
        @(posedge clk);
        #2;
        instr = word;
        rj_value = rj;
        rd_value = rd;
        pc = pc_now;
        req = 1'b1;
        pc_now = pc_now + 32'd4;
        t = 0;
        while (!ack && t < 20) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!ack) begin
            $display("no ack for instruction %h", word);
            tb_errors++;
        end
        last_rdata = rdata;
        #1 req = 1'b0;
        t = 0;
        while (ack && t < 20) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (t > 1) begin
            $display("ack did not fall on the first edge after req dropped for instruction %h",
                     word);
            tb_errors++;
        end
    endtask

    task automatic csr_read(input logic [13:0] num);
        run_cmd(csr_word(num, 5'd0), 32'h0, 32'h0);
    endtask

    task automatic csr_write(input logic [13:0] num, input logic [31:0] data);
        run_cmd(csr_word(num, 5'd1), 32'h0, data);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            tb_errors++;
        end
    endtask

    // the run has no more than about 100 commands plus one timer wait
    initial begin
        #(40 * (100 * 20 + 40 + 10));
        $display("timeout: the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int idx;
        int k;
        logic [31:0] data;
        clk = 1'b0;
        rstn = 1'b0;
        req = 1'b0;
        instr = 32'h0;
        rj_value = 32'h0;
        rd_value = 32'h0;
        pc = 32'h0;
        hw_int = 8'h0;
        regs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ECFG, CSR_EENTRY, CSR_TID};
        repeat (5) @(posedge clk);
        #2 rstn = 1'b1;

        // reset values
        foreach (regs[i]) csr_read(regs[i]);
        csr_read(CSR_CRMD);
        csr_read(CSR_PRMD);
        csr_read(CSR_ESTAT);
        csr_read(CSR_ERA);
        csr_read(CSR_TCFG);
        csr_read(CSR_TVAL);
        expect_value("tval", last_rdata, 32'hffff_ffff);

        // random masked writes
        for (int n = 0; n < 12; n++) begin
            idx = $unsigned($random(seed)) % 7;
            data = $random(seed);
            if ($random(seed) & 1) csr_write(regs[idx], data);
            else run_cmd(csr_word(regs[idx], 5'd2), $random(seed), data);
        end
        foreach (regs[i]) csr_read(regs[i]);

        // syscall, break, illegal word
        csr_write(CSR_EENTRY, 32'h1c00_0140);
        csr_write(CSR_CRMD, 32'h0000_0007);     // plv3, ie on
        exc_words[0] = code_word(OPC_SYSCALL, 15'h12);
        exc_words[1] = code_word(OPC_BREAK, 15'h3);
        exc_words[2] = 32'hffff_ffff;
        foreach (exc_words[i]) begin
            run_cmd(exc_words[i], 32'h0, 32'h0);
            csr_read(CSR_ERA);
            csr_read(CSR_ESTAT);
            csr_read(CSR_PRMD);
            run_cmd(INSTR_ERTN, 32'h0, 32'h0);
            csr_read(CSR_CRMD);
        end
        csr_write(CSR_CRMD, 32'h0000_0003);     // ie off while the timer runs

        // one-shot timer, init value 0x20
        csr_write(CSR_TCFG, 32'h0000_0021);
        k = 0;
        do begin
            csr_read(CSR_ESTAT);
            k++;
        end while (!last_rdata[11] && k < 20);
        if (!last_rdata[11]) begin
            $display("timer interrupt never showed up in ESTAT");
            tb_errors++;
        end
        csr_write(CSR_TICLR, 32'h1);
        csr_read(CSR_ESTAT);
        expect_value("estat_ti", {31'h0, last_rdata[11]}, 32'h0);
        csr_read(CSR_TVAL);
        expect_value("tval", last_rdata, 32'hffff_ffff);

        // hardware interrupt takes the next command
        csr_write(CSR_ECFG, 32'h0000_0004);
        hw_int = 8'h01;
        csr_write(CSR_CRMD, 32'h0000_0004);
        k = 0;
        while (!has_int && k < 10) begin
            @(posedge clk);
            #2;
            k++;
        end
        if (!has_int) begin
            $display("has_int did not rise with ie, ecfg and hw_int set");
            tb_errors++;
        end
        csr_write(CSR_SAVE1, $random(seed));
        hw_int = 8'h00;
        csr_read(CSR_SAVE1);
        csr_read(CSR_ESTAT);
        csr_read(CSR_CRMD);

        repeat (5) @(posedge clk);
        total = tb_errors + u_checker.errors;
        $display("errors: %0d from checker, %0d from testbench", u_checker.errors, tb_errors);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/csr_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_checker import csr_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req,
    input  logic        ack,
    input  logic [31:0] instr,
    input  logic [31:0] rj_value,
    input  logic [31:0] rd_value,
    input  logic [31:0] pc,
    input  logic [7:0]  hw_int,
    input  logic [31:0] rdata,
    input  logic        redirect,
    input  logic [31:0] redirect_pc
);

    // model of the kept registers
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] ecfg;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] tid;
    logic [31:0] tcfg;
    logic [31:0] save [4];
    logic [1:0]  est_soft;
    logic [5:0]  est_code;

    int          errors = 0;
    int          state = 0;     // 0 idle, 1 waiting for ack, 2 waiting for req low
    int          cnt;
    logic [96:0] expected;      // cmp mask, redirect, target, rdata

    function automatic logic [31:0] masked_update(input logic [31:0] old,
                                                  input logic [31:0] data,
                                                  input logic [31:0] m);
        masked_update = (old & ~m) | (data & m);
    endfunction

    function automatic logic [2:0] classify(input logic [31:0] word);
        csr_instr_u iw;
        iw = word;
        if (iw.csr.op == OPC_CSR) begin
            if (iw.csr.rj == 5'd0) return OP_RD;
            if (iw.csr.rj == 5'd1) return OP_WR;
            return OP_XCHG;
        end
        if (iw.code.op == OPC_SYSCALL) return OP_SYS;
        if (iw.code.op == OPC_BREAK) return OP_BRK;
        if (word == INSTR_ERTN) return OP_ERTN;
        return OP_INE;
    endfunction

    // timer bit 11 left at zero here
    function automatic logic [31:0] model_read(input logic [13:0] num, input logic [7:0] hw);
        case (num)
            CSR_CRMD:   return crmd;
            CSR_PRMD:   return prmd;
            CSR_ECFG:   return ecfg;
            CSR_ESTAT:  return {10'h0, est_code, 6'h0, hw, est_soft};
            CSR_ERA:    return era;
            CSR_EENTRY: return eentry;
            CSR_SAVE0:  return save[0];
            CSR_SAVE1:  return save[1];
            CSR_SAVE2:  return save[2];
            CSR_SAVE3:  return save[3];
            CSR_TID:    return tid;
            CSR_TCFG:   return tcfg;
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic irq_pending(input logic [7:0] hw);
        logic [31:0] est;
        est = model_read(CSR_ESTAT, hw);
        return crmd[2] && (|(ecfg[12:0] & est[12:0]));
    endfunction

    function automatic logic [96:0] expect_response(input logic [31:0] word,
                                                    input logic [7:0] hw);
        csr_instr_u  iw;
        logic [2:0]  kind;
        logic [31:0] m;
        iw = word;
        kind = classify(word);
        if (irq_pending(hw) || kind == OP_SYS || kind == OP_BRK || kind == OP_INE) begin
            return {32'h0, 1'b1, eentry, 32'h0};
        end
        if (kind == OP_ERTN) return {32'h0, 1'b1, era, 32'h0};
        if (iw.csr.csr_num == CSR_TVAL) m = 32'h0;          // timer checked by polling
        else if (iw.csr.csr_num == CSR_ESTAT) m = 32'hffff_f7ff;
        else m = 32'hffff_ffff;
        return {m, 1'b0, 32'h0, model_read(iw.csr.csr_num, hw)};
    endfunction

    task automatic update_model(input logic [31:0] word, input logic [31:0] rj,
                                input logic [31:0] rd, input logic [31:0] cmd_pc,
                                input logic [7:0] hw);
        csr_instr_u  iw;
        logic [2:0]  kind;
        logic [31:0] m;
        logic [31:0] tmp;
        logic        irq;
        iw = word;
        kind = classify(word);
        irq = irq_pending(hw);
        if (irq || kind == OP_SYS || kind == OP_BRK || kind == OP_INE) begin
            prmd[2:0] = crmd[2:0];
            crmd[2:0] = 3'b000;
            era = cmd_pc;
            if (irq) est_code = ECODE_INT;
            else if (kind == OP_SYS) est_code = ECODE_SYS;
            else if (kind == OP_BRK) est_code = ECODE_BRK;
            else est_code = ECODE_INE;
        end else if (kind == OP_ERTN) begin
            crmd[2:0] = prmd[2:0];
        end else if (kind == OP_WR || kind == OP_XCHG) begin
            m = (kind == OP_XCHG) ? rj : 32'hffff_ffff;
            case (iw.csr.csr_num)
                CSR_CRMD:   crmd = masked_update(crmd, rd, m & WMASK_CRMD);
                CSR_PRMD:   prmd = masked_update(prmd, rd, m & WMASK_PRMD);
                CSR_ECFG:   ecfg = masked_update(ecfg, rd, m & WMASK_ECFG);
                CSR_ESTAT: begin
                    tmp = masked_update({30'h0, est_soft}, rd, m & WMASK_ESTAT);
                    est_soft = tmp[1:0];
                end
                CSR_ERA:    era = masked_update(era, rd, m & WMASK_ERA);
                CSR_EENTRY: eentry = masked_update(eentry, rd, m & WMASK_EENTRY);
                CSR_SAVE0:  save[0] = masked_update(save[0], rd, m & WMASK_SAVE);
                CSR_SAVE1:  save[1] = masked_update(save[1], rd, m & WMASK_SAVE);
                CSR_SAVE2:  save[2] = masked_update(save[2], rd, m & WMASK_SAVE);
                CSR_SAVE3:  save[3] = masked_update(save[3], rd, m & WMASK_SAVE);
                CSR_TID:    tid = masked_update(tid, rd, m & WMASK_TID);
                CSR_TCFG:   tcfg = masked_update(tcfg, rd, m & WMASK_TCFG);
                default: ;
            endcase
        end
    endtask

    task automatic compare_response();
        logic [31:0] m;
        m = expected[96:65];
        if ((rdata & m) != (expected[31:0] & m)) begin
            $display("FAIL rdata: got %h expected %h", rdata & m, expected[31:0] & m);
            errors++;
        end
        if (redirect != expected[64]) begin
            $display("FAIL redirect: got %h expected %h", redirect, expected[64]);
            errors++;
        end
        if (expected[64] && redirect_pc != expected[63:32]) begin
            $display("FAIL redirect_pc: got %h expected %h", redirect_pc, expected[63:32]);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (!rstn) begin
            crmd = CRMD_RESET;
            prmd = 32'h0;
            ecfg = 32'h0;
            era = 32'h0;
            eentry = 32'h0;
            tid = 32'h0;
            tcfg = 32'h0;
            for (int i = 0; i < 4; i++) save[i] = 32'h0;
            est_soft = 2'b00;
            est_code = 6'h0;
            state = 0;
        end else if (state == 0) begin
            if (ack) begin
                $display("handshake fault: ack high with no command in flight");
                errors++;
            end else if (req) begin
                expected = expect_response(instr, hw_int);
                update_model(instr, rj_value, rd_value, pc, hw_int);
                cnt = 0;
                state = 1;
            end
        end else if (state == 1) begin
            cnt++;
            if (ack) begin
                if (cnt != 3) begin
                    $display("handshake fault: ack came %0d cycles after req instead of 2",
                             cnt - 1);
                    errors++;
                end
                compare_response();
                state = 2;
            end else if (cnt == 4) begin
                $display("handshake fault: ack late for instr %h", instr);
                errors++;
            end
        end else if (!req && !ack) begin
            state = 0;
        end
    end

endmodule

`default_nettype wire

/* source/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req,
    output logic        ack,
    input  logic [31:0] instr,
    input  logic [31:0] rj_value,
    input  logic [31:0] rd_value,
    input  logic [31:0] pc,
    input  logic [7:0]  hw_int,
    output logic [31:0] rdata,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        has_int
);

    // decode -> trap
    logic        valid;
    logic [2:0]  op;
    logic [13:0] csr_num;
    logic [31:0] rj_q;
    logic [31:0] rd_q;
    logic [31:0] pc_q;
    logic        done;

    // trap <-> file
    logic        acc_we;
    logic [31:0] wr_data;
    logic [31:0] wr_mask;
    logic        ex_en;
    logic [5:0]  ecode;
    logic        ertn;
    logic [13:0] rd_num;
    logic [31:0] csr_value;
    logic [31:0] eentry;
    logic [31:0] era;

    csr_decode u_decode (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .ack      (ack),
        .instr    (instr),
        .rj_value (rj_value),
        .rd_value (rd_value),
        .pc       (pc),
        .done     (done),
        .valid    (valid),
        .op       (op),
        .csr_num  (csr_num),
        .rj_q     (rj_q),
        .rd_q     (rd_q),
        .pc_q     (pc_q)
    );

    csr_trap u_trap (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .op          (op),
        .csr_num     (csr_num),
        .rj_value    (rj_q),
        .rd_value    (rd_q),
        .pc          (pc_q),
        .csr_value   (csr_value),
        .eentry      (eentry),
        .era         (era),
        .has_int     (has_int),
        .acc_we      (acc_we),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask),
        .ex_en       (ex_en),
        .ecode       (ecode),
        .ertn        (ertn),
        .rd_num      (rd_num),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .done        (done)
    );

    // same register is read and written by one command
    csr_file u_file (
        .clk       (clk),
        .rstn      (rstn),
        .acc_we    (acc_we),
        .wr_num    (rd_num),
        .wr_data   (wr_data),
        .wr_mask   (wr_mask),
        .ex_en     (ex_en),
        .ecode     (ecode),
        .pc        (pc_q),
        .ertn      (ertn),
        .rd_num    (rd_num),
        .hw_int    (hw_int),
        .csr_value (csr_value),
        .eentry    (eentry),
        .era       (era),
        .has_int   (has_int)
    );

endmodule

`default_nettype wire

/* source/csr_trap.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap import csr_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        valid,
    input  logic [2:0]  op,
    input  logic [13:0] csr_num,
    input  logic [31:0] rj_value,
    input  logic [31:0] rd_value,
    input  logic [31:0] pc,
    input  logic [31:0] csr_value,
    input  logic [31:0] eentry,
    input  logic [31:0] era,
    input  logic        has_int,
    output logic        acc_we,
    output logic [31:0] wr_data,
    output logic [31:0] wr_mask,
    output logic        ex_en,
    output logic [5:0]  ecode,
    output logic        ertn,
    output logic [13:0] rd_num,
    output logic [31:0] rdata,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        done
);

    logic is_exc;
    logic is_acc;

    assign is_exc = (op == OP_SYS) || (op == OP_BRK) || (op == OP_INE);
    assign is_acc = (op == OP_RD) || (op == OP_WR) || (op == OP_XCHG);

    // a pending interrupt replaces the command
    assign ex_en   = valid && (has_int || is_exc);
    assign ertn    = valid && !has_int && (op == OP_ERTN);
    assign acc_we  = valid && !has_int && ((op == OP_WR) || (op == OP_XCHG));
    assign wr_data = rd_value;
    assign wr_mask = (op == OP_XCHG) ? rj_value : 32'hffff_ffff;
    assign rd_num  = csr_num;

    always_comb begin
        if (has_int) begin
            ecode = ECODE_INT;
        end else begin
            case (op)
                OP_SYS:  ecode = ECODE_SYS;
                OP_BRK:  ecode = ECODE_BRK;
                default: ecode = ECODE_INE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            redirect <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= valid;
            if (valid) begin
                redirect <= ex_en || ertn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            rdata <= (is_acc && !has_int) ? csr_value : 32'h0;  // old value
            if (ex_en) begin
                redirect_pc <= eentry;
            end else if (ertn) begin
                redirect_pc <= era;
            end else begin
                redirect_pc <= pc + 32'd4;      // fall through
            end
        end
    end

endmodule

`default_nettype wire

/* source/csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode import csr_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req,
    output logic        ack,
    input  logic [31:0] instr,
    input  logic [31:0] rj_value,
    input  logic [31:0] rd_value,
    input  logic [31:0] pc,
    input  logic        done,
    output logic        valid,
    output logic [2:0]  op,
    output logic [13:0] csr_num,
    output logic [31:0] rj_q,
    output logic [31:0] rd_q,
    output logic [31:0] pc_q
);

    csr_instr_u iw;
    logic       busy;       // held from accept until req drops
    logic       accept;
    logic [2:0] op_d;

    assign iw     = instr;
    assign accept = req && !busy;

    always_comb begin
        if (iw.csr.op == OPC_CSR) begin
            // rj field selects the access flavour
            case (iw.csr.rj)
                5'd0:    op_d = OP_RD;
                5'd1:    op_d = OP_WR;
                default: op_d = OP_XCHG;
            endcase
        end else if (iw.code.op == OPC_SYSCALL) begin
            op_d = OP_SYS;
        end else if (iw.code.op == OPC_BREAK) begin
            op_d = OP_BRK;
        end else if (iw == INSTR_ERTN) begin
            op_d = OP_ERTN;
        end else begin
            op_d = OP_INE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy  <= 1'b0;
            valid <= 1'b0;
            ack   <= 1'b0;
        end else begin
            valid <= accept;        // one pulse per req
            if (accept) begin
                busy <= 1'b1;
            end else if (!req) begin
                busy <= 1'b0;
            end
            if (done) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op      <= op_d;
            csr_num <= iw.csr.csr_num;
            rj_q    <= rj_value;
            rd_q    <= rd_value;
            pc_q    <= pc;
        end
    end

endmodule

`default_nettype wire

/* source/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        acc_we,
    input  logic [13:0] wr_num,
    input  logic [31:0] wr_data,
    input  logic [31:0] wr_mask,
    input  logic        ex_en,
    input  logic [5:0]  ecode,
    input  logic [31:0] pc,
    input  logic        ertn,
    input  logic [13:0] rd_num,
    input  logic [7:0]  hw_int,
    output logic [31:0] csr_value,
    output logic [31:0] eentry,
    output logic [31:0] era,
    output logic        has_int
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] ecfg;
    logic [31:0] estat;
    logic [31:0] save [4];
    logic [31:0] tid;
    logic [31:0] tcfg;
    logic [31:0] estat_new;

    logic        crmd_we;
    logic        prmd_we;
    logic        ecfg_we;
    logic        estat_we;
    logic        era_we;
    logic        eentry_we;
    logic        save_we;
    logic        tid_we;

    // timer side
    logic        tcfg_we;
    logic [31:0] tcfg_wdata;
    logic        ticlr_we;
    logic [31:0] tval;
    logic        timer_irq_set;
    logic        timer_irq_clr;

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [31:0] mask);
        merge = (old & ~mask) | (data & mask);
    endfunction

    assign crmd_we   = acc_we && (wr_num == CSR_CRMD);
    assign prmd_we   = acc_we && (wr_num == CSR_PRMD);
    assign ecfg_we   = acc_we && (wr_num == CSR_ECFG);
    assign estat_we  = acc_we && (wr_num == CSR_ESTAT);
    assign era_we    = acc_we && (wr_num == CSR_ERA);
    assign eentry_we = acc_we && (wr_num == CSR_EENTRY);
    assign save_we   = acc_we && (wr_num[13:2] == CSR_SAVE0[13:2]);    // save0..3
    assign tid_we    = acc_we && (wr_num == CSR_TID);
    assign tcfg_we   = acc_we && (wr_num == CSR_TCFG);
    assign ticlr_we  = acc_we && (wr_num == CSR_TICLR) && wr_data[0] && wr_mask[0];

    assign tcfg_wdata = merge(tcfg, wr_data, wr_mask & WMASK_TCFG);
    assign estat_new  = merge(estat, wr_data, wr_mask & WMASK_ESTAT);

    assign has_int = crmd[2] && |(ecfg[12:0] & estat[12:0]);

    csr_timer u_timer (
        .clk           (clk),
        .rstn          (rstn),
        .tcfg_we       (tcfg_we),
        .tcfg_wdata    (tcfg_wdata),
        .ticlr_we      (ticlr_we),
        .tval          (tval),
        .timer_irq_set (timer_irq_set),
        .timer_irq_clr (timer_irq_clr)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd <= CRMD_RESET;
            prmd <= 32'h0;
        end else if (ex_en) begin
            prmd[2:0] <= crmd[2:0];     // pie, pplv
            crmd[2:0] <= 3'b000;
        end else if (ertn) begin
            crmd[2:0] <= prmd[2:0];
        end else begin
            if (crmd_we) begin
                crmd <= merge(crmd, wr_data, wr_mask & WMASK_CRMD);
            end
            if (prmd_we) begin
                prmd <= merge(prmd, wr_data, wr_mask & WMASK_PRMD);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            estat <= 32'h0;
        end else begin
            estat[9:2] <= hw_int;
            if (timer_irq_clr) begin
                estat[11] <= 1'b0;
            end else if (timer_irq_set) begin
                estat[11] <= 1'b1;
            end
            if (ex_en) begin
                estat[21:16] <= ecode;
            end else if (estat_we) begin
                estat[1:0] <= estat_new[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg   <= 32'h0;
            era    <= 32'h0;
            eentry <= 32'h0;
            tid    <= 32'h0;
            tcfg   <= 32'h0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= 32'h0;
            end
        end else begin
            if (ecfg_we) ecfg <= merge(ecfg, wr_data, wr_mask & WMASK_ECFG);
            if (ex_en) begin
                era <= pc;
            end else if (era_we) begin
                era <= merge(era, wr_data, wr_mask & WMASK_ERA);
            end
            if (eentry_we) eentry <= merge(eentry, wr_data, wr_mask & WMASK_EENTRY);
            if (tid_we) tid <= merge(tid, wr_data, wr_mask & WMASK_TID);
            if (tcfg_we) tcfg <= tcfg_wdata;
            if (save_we) begin
                save[wr_num[1:0]] <= merge(save[wr_num[1:0]], wr_data, wr_mask & WMASK_SAVE);
            end
        end
    end

    always_comb begin
        case (rd_num)
            CSR_CRMD:   csr_value = crmd;
            CSR_PRMD:   csr_value = prmd;
            CSR_ECFG:   csr_value = ecfg;
            CSR_ESTAT:  csr_value = estat;
            CSR_ERA:    csr_value = era;
            CSR_EENTRY: csr_value = eentry;
            CSR_SAVE0:  csr_value = save[0];
            CSR_SAVE1:  csr_value = save[1];
            CSR_SAVE2:  csr_value = save[2];
            CSR_SAVE3:  csr_value = save[3];
            CSR_TID:    csr_value = tid;
            CSR_TCFG:   csr_value = tcfg;
            CSR_TVAL:   csr_value = tval;
            CSR_TICLR:  csr_value = 32'h0;     // write only
            default:    csr_value = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

/* source/csr_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  logic        clk,
    input  logic        rstn,
    input  logic        tcfg_we,
    input  logic [31:0] tcfg_wdata,
    input  logic        ticlr_we,
    output logic [31:0] tval,
    output logic        timer_irq_set,
    output logic        timer_irq_clr
);

    logic        en;
    logic        periodic;
    logic [29:0] init_val;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en            <= 1'b0;
            periodic      <= 1'b0;
            tval          <= 32'hffff_ffff;
            timer_irq_set <= 1'b0;
            timer_irq_clr <= 1'b0;
        end else begin
            timer_irq_set <= 1'b0;
            timer_irq_clr <= ticlr_we;
            if (tcfg_we) begin
                en       <= tcfg_wdata[0];
                periodic <= tcfg_wdata[1];
                tval     <= {tcfg_wdata[31:2], 2'b00};
            end else if (en) begin
                if (tval != 32'h0) begin
                    tval <= tval - 32'd1;
                end else begin
                    // expired
                    timer_irq_set <= 1'b1;
                    en            <= periodic;
                    tval          <= periodic ? {init_val, 2'b00} : 32'hffff_ffff;
                end
            end
        end
    end

    // reload value for periodic mode
    always_ff @(posedge clk) begin
        if (tcfg_we) begin
            init_val <= tcfg_wdata[31:2];
        end
    end

endmodule

`default_nettype wire

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // register numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;
    localparam logic [13:0] CSR_TID    = 14'h040;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    // estat.ecode values
    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_SYS = 6'h0b;
    localparam logic [5:0] ECODE_BRK = 6'h0c;
    localparam logic [5:0] ECODE_INE = 6'h0d;

    // instruction encodings
    localparam logic [7:0]  OPC_CSR     = 8'h04;        // csrrd/csrwr/csrxchg
    localparam logic [16:0] OPC_SYSCALL = 17'h00056;
    localparam logic [16:0] OPC_BREAK   = 17'h00054;
    localparam logic [31:0] INSTR_ERTN  = 32'h0648_3800;

    // software writable bits per register
    localparam logic [31:0] WMASK_CRMD   = 32'h0000_01ff;
    localparam logic [31:0] WMASK_PRMD   = 32'h0000_0007;
    localparam logic [31:0] WMASK_ECFG   = 32'h0000_1bff;   // lie bit 10 reserved
    localparam logic [31:0] WMASK_ESTAT  = 32'h0000_0003;   // soft int bits only
    localparam logic [31:0] WMASK_ERA    = 32'hffff_ffff;
    localparam logic [31:0] WMASK_EENTRY = 32'hffff_ffc0;
    localparam logic [31:0] WMASK_SAVE   = 32'hffff_ffff;
    localparam logic [31:0] WMASK_TID    = 32'hffff_ffff;
    localparam logic [31:0] WMASK_TCFG   = 32'hffff_ffff;

    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;     // da=1, plv0, ie off

    // op codes from decode to trap
    localparam logic [2:0] OP_RD   = 3'd0;
    localparam logic [2:0] OP_WR   = 3'd1;
    localparam logic [2:0] OP_XCHG = 3'd2;
    localparam logic [2:0] OP_SYS  = 3'd3;
    localparam logic [2:0] OP_BRK  = 3'd4;
    localparam logic [2:0] OP_ERTN = 3'd5;
    localparam logic [2:0] OP_INE  = 3'd6;

    // one instruction word, seen as csr access or as syscall/break
    typedef union packed {
        struct packed {
            logic [7:0]  op;
            logic [13:0] csr_num;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } csr;
        struct packed {
            logic [16:0] op;
            logic [14:0] code;
        } code;
    } csr_instr_u;

endpackage

`default_nettype wire
